// ==== hw/branchResolver.sv ====
// Branch resolver
// Evaluates branch conditions and picks the next fetch address
`timescale 1ns/1ps
`default_nettype none

module branchResolver import decodePkg::*; (
	input instrWord instr,
	input logic [wordWidth-1:0] pca,
	input logic [wordWidth-1:0] readDataA,
	input logic [wordWidth-1:0] readDataB,
	input logic jump,
	input logic branch,
	output logic branchTaken,
	output logic [wordWidth-1:0] nextPc
);

	logic signed [wordWidth-1:0] valueA;
	logic signed [wordWidth-1:0] valueB;
	logic condition;
	logic registerJump;
	logic [wordWidth-1:0] jumpTarget;
	logic [wordWidth-1:0] branchTarget;

	assign valueA = $signed(readDataA);
	assign valueB = $signed(readDataB);

	always_comb begin
		case (instr.i.opcode)
			opBeq: condition = (valueA == valueB);
			opBne: condition = (valueA != valueB);
			opBlez: condition = (valueA <= 0);
			opBgtz: condition = (valueA > 0);
			opRegimm: begin
				if (instr.i.rt == rtBgez)
					condition = (valueA >= 0);
				else
					condition = (valueA < 0);
			end
			default: condition = 1'b0;
		endcase
	end

	// jr and jalr are the only jumps under SPECIAL
	assign registerJump = jump && (instr.r.opcode == opSpecial);

	assign jumpTarget = {pca[wordWidth-1:wordWidth-4], instr.j.target, 2'b00};
	assign branchTarget = pca + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

	assign branchTaken = jump || (branch && condition);

	always_comb begin
		if (registerJump)
			nextPc = readDataA;
		else if (jump)
			nextPc = jumpTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pca;
	end

endmodule

`default_nettype wire

// ==== hw/decodePkg.sv ====
// Decode stage package
// Widths, ALU operation codes, opcode and funct values, instruction word views
`default_nettype none

package decodePkg;

	parameter int wordWidth = 32;

	typedef logic [4:0] regIndex;
	typedef logic [5:0] aluOp;

	// --------------------------------------------------
	// ALU operation codes
	// --------------------------------------------------
	localparam aluOp aluAdd = 6'b000000;
	localparam aluOp aluAddi = 6'b000001;
	localparam aluOp aluAddiu = 6'b000010;
	localparam aluOp aluAnd = 6'b000100;
	localparam aluOp aluLui = 6'b001000;
	// Jump target passes straight through
	localparam aluOp aluPassB = 6'b001110;
	localparam aluOp aluNor = 6'b001111;
	localparam aluOp aluOr = 6'b010000;
	localparam aluOp aluSll = 6'b010011;
	localparam aluOp aluSllv = 6'b010100;
	localparam aluOp aluSlt = 6'b010101;
	localparam aluOp aluSra = 6'b011001;
	localparam aluOp aluSrav = 6'b011010;
	localparam aluOp aluSrl = 6'b011011;
	localparam aluOp aluSrlv = 6'b011100;
	localparam aluOp aluSub = 6'b011101;
	localparam aluOp aluSubu = 6'b011110;
	localparam aluOp aluXor = 6'b011111;
	localparam aluOp aluXori = 6'b100000;
	localparam aluOp aluAddu = 6'b110111;
	localparam aluOp aluSltu = 6'b111111;
	localparam aluOp aluJr = 6'b111110;

	// Branch codes
	localparam aluOp aluBeq = 6'b100010;
	localparam aluOp aluBgez = 6'b100011;
	localparam aluOp aluBgtz = 6'b100101;
	localparam aluOp aluBlez = 6'b100110;
	localparam aluOp aluBltz = 6'b100111;
	localparam aluOp aluBne = 6'b101001;

	// Memory access codes
	localparam aluOp aluLb = 6'b100001;
	localparam aluOp aluLbu = 6'b101010;
	localparam aluOp aluLh = 6'b101011;
	localparam aluOp aluLhu = 6'b101100;
	localparam aluOp aluLw = 6'b111101;
	localparam aluOp aluSb = 6'b101111;
	localparam aluOp aluSh = 6'b110000;
	localparam aluOp aluSw = 6'b110001;

	// --------------------------------------------------
	// Opcode, funct and REGIMM rt values
	// --------------------------------------------------
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm = 6'b000001;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opJal = 6'b000011;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBne = 6'b000101;
	localparam logic [5:0] opBlez = 6'b000110;
	localparam logic [5:0] opBgtz = 6'b000111;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opLb = 6'b100000;
	localparam logic [5:0] opLh = 6'b100001;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opLbu = 6'b100100;
	localparam logic [5:0] opLhu = 6'b100101;
	localparam logic [5:0] opSb = 6'b101000;
	localparam logic [5:0] opSh = 6'b101001;
	localparam logic [5:0] opSw = 6'b101011;

	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnJr = 6'b001000;
	localparam logic [5:0] fnJalr = 6'b001001;
	localparam logic [5:0] fnSyscall = 6'b001100;
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	localparam regIndex rtBltz = 5'b00000;
	localparam regIndex rtBgez = 5'b00001;

	localparam regIndex linkRegister = 5'd31;
	localparam regIndex syscallOperandReg = 5'd2;

	// Same 32 bits seen as R, I or J format
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			regIndex rs;
			regIndex rt;
			regIndex rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			regIndex rs;
			regIndex rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] target;
		} j;
	} instrWord;

endpackage

`default_nettype wire

// ==== hw/decodeStage.sv ====
// MIPS instruction decode stage
// Decoder, register file, branch resolver and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*; (
	input logic CLK,
	input logic RESET,
	input instrWord instr,
	input logic [wordWidth-1:0] pca,
	input logic [wordWidth-1:0] r2Input,
	input logic wbEnable,
	input regIndex wbReg,
	input logic [wordWidth-1:0] wbData,
	input logic freeze,
	input logic insertBubble,
	output logic branchTaken,
	output logic [wordWidth-1:0] nextPc,
	output logic [wordWidth-1:0] operandA,
	output logic [wordWidth-1:0] operandB,
	output logic [wordWidth-1:0] readDataBOut,
	output logic [wordWidth-1:0] destValueOut,
	output logic [wordWidth-1:0] instrOut,
	output regIndex writeRegOut,
	output regIndex readRegAOut,
	output regIndex readRegBOut,
	output regIndex shamtOut,
	output aluOp aluControlOut,
	output logic memReadOut,
	output logic memToRegOut,
	output logic memWriteOut,
	output logic aluSrcOut,
	output logic doWriteback,
	output logic branchTakenOut
);

	regIndex writeReg;
	logic link;
	logic jump;
	logic branch;
	logic memRead;
	logic memToReg;
	logic memWrite;
	logic aluSrc;
	logic regWrite;
	logic syscall;
	aluOp aluControl;
	logic [wordWidth-1:0] readDataA;
	logic [wordWidth-1:0] readDataB;
	logic [wordWidth-1:0] destValue;

	instrDecoder instrDecoder_i (
		.instr(instr),
		.writeReg(writeReg),
		.link(link),
		.jump(jump),
		.branch(branch),
		.memRead(memRead),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.regWrite(regWrite),
		.syscall(syscall),
		.aluControl(aluControl)
	);

	// Third port reads the old value of the destination
	regFile regFile_i (
		.CLK(CLK),
		.readRegA(instr.r.rs),
		.readRegB(instr.r.rt),
		.readRegC(writeReg),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.readDataC(destValue)
	);

	branchResolver branchResolver_i (
		.instr(instr),
		.pca(pca),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.jump(jump),
		.branch(branch),
		.branchTaken(branchTaken),
		.nextPc(nextPc)
	);

	idExRegister idExRegister_i (
		.CLK(CLK),
		.RESET(RESET),
		.freeze(freeze),
		.insertBubble(insertBubble),
		.instr(instr),
		.pca(pca),
		.r2Input(r2Input),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.destValue(destValue),
		.writeReg(writeReg),
		.link(link),
		.syscall(syscall),
		.memRead(memRead),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.regWrite(regWrite),
		.branchTaken(branchTaken),
		.aluControl(aluControl),
		.operandA(operandA),
		.operandB(operandB),
		.readDataBOut(readDataBOut),
		.destValueOut(destValueOut),
		.instrOut(instrOut),
		.writeRegOut(writeRegOut),
		.readRegAOut(readRegAOut),
		.readRegBOut(readRegBOut),
		.shamtOut(shamtOut),
		.aluControlOut(aluControlOut),
		.memReadOut(memReadOut),
		.memToRegOut(memToRegOut),
		.memWriteOut(memWriteOut),
		.aluSrcOut(aluSrcOut),
		.doWriteback(doWriteback),
		.branchTakenOut(branchTakenOut)
	);

endmodule

`default_nettype wire

// ==== hw/idExRegister.sv ====
// ID/EX pipeline register
// Picks link and syscall operands, holds on freeze, clears on bubble
`timescale 1ns/1ps
`default_nettype none

module idExRegister import decodePkg::*; (
	input logic CLK,
	input logic RESET,
	input logic freeze,
	input logic insertBubble,
	input instrWord instr,
	input logic [wordWidth-1:0] pca,
	input logic [wordWidth-1:0] r2Input,
	input logic [wordWidth-1:0] readDataA,
	input logic [wordWidth-1:0] readDataB,
	input logic [wordWidth-1:0] destValue,
	input regIndex writeReg,
	input logic link,
	input logic syscall,
	input logic memRead,
	input logic memToReg,
	input logic memWrite,
	input logic aluSrc,
	input logic regWrite,
	input logic branchTaken,
	input aluOp aluControl,
	output logic [wordWidth-1:0] operandA,
	output logic [wordWidth-1:0] operandB,
	output logic [wordWidth-1:0] readDataBOut,
	output logic [wordWidth-1:0] destValueOut,
	output logic [wordWidth-1:0] instrOut,
	output regIndex writeRegOut,
	output regIndex readRegAOut,
	output regIndex readRegBOut,
	output regIndex shamtOut,
	output aluOp aluControlOut,
	output logic memReadOut,
	output logic memToRegOut,
	output logic memWriteOut,
	output logic aluSrcOut,
	output logic doWriteback,
	output logic branchTakenOut
);

	logic [wordWidth-1:0] nextOperandA;
	logic [wordWidth-1:0] nextOperandB;
	logic clearA;
	logic clearB;

	// --------------------------------------------------
	// Operand selection
	// --------------------------------------------------
	always_comb begin
		if (link) begin
			nextOperandA = pca;
			nextOperandB = wordWidth'(4);
		end else if (syscall) begin
			nextOperandA = r2Input;
			nextOperandB = '0;
		end else begin
			nextOperandA = readDataA;
			nextOperandB = readDataB;
		end
	end

	// No register source means nothing to forward
	assign clearA = link || syscall;
	assign clearB = aluSrc || link || syscall;

	// --------------------------------------------------
	// Pipeline register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			{operandA, operandB, readDataBOut, destValueOut, instrOut} <= '0;
			{writeRegOut, readRegAOut, readRegBOut, shamtOut, aluControlOut} <= '0;
			{memReadOut, memToRegOut, memWriteOut, aluSrcOut} <= '0;
			{doWriteback, branchTakenOut} <= '0;
		end else if (insertBubble) begin
			{operandA, operandB, readDataBOut, destValueOut, instrOut} <= '0;
			{writeRegOut, readRegAOut, readRegBOut, shamtOut, aluControlOut} <= '0;
			{memReadOut, memToRegOut, memWriteOut, aluSrcOut} <= '0;
			{doWriteback, branchTakenOut} <= '0;
		end else if (!freeze) begin
			operandA <= nextOperandA;
			operandB <= nextOperandB;
			readDataBOut <= readDataB;
			destValueOut <= destValue;
			instrOut <= instr;
			writeRegOut <= writeReg;
			readRegAOut <= clearA ? regIndex'(0) : instr.r.rs;
			readRegBOut <= clearB ? regIndex'(0) : instr.r.rt;
			shamtOut <= instr.r.shamt;
			aluControlOut <= aluControl;
			memReadOut <= memRead;
			memToRegOut <= memToReg;
			memWriteOut <= memWrite;
			aluSrcOut <= aluSrc;
			doWriteback <= regWrite || memToReg;
			branchTakenOut <= branchTaken;
		end
	end

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
// Instruction decoder
// Turns one instruction word into control levels and a destination register
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import decodePkg::*; (
	input instrWord instr,
	output regIndex writeReg,
	output logic link,
	output logic jump,
	output logic branch,
	output logic memRead,
	output logic memToReg,
	output logic memWrite,
	output logic aluSrc,
	output logic regWrite,
	output logic syscall,
	output aluOp aluControl
);

	// {link, regDst, jump, branch, memRead, memToReg, memWrite, aluSrc, regWrite, syscall}
	localparam logic [9:0] ctrlNone = 10'b0000000000;
	localparam logic [9:0] ctrlRType = 10'b0100000010;
	localparam logic [9:0] ctrlImm = 10'b0000000110;
	localparam logic [9:0] ctrlLoad = 10'b0000110110;
	localparam logic [9:0] ctrlStore = 10'b0000001100;
	localparam logic [9:0] ctrlBranch = 10'b0001000000;
	localparam logic [9:0] ctrlJump = 10'b0011000000;
	localparam logic [9:0] ctrlJal = 10'b1010000110;
	localparam logic [9:0] ctrlJalr = 10'b1011000010;
	localparam logic [9:0] ctrlSyscall = 10'b0000000111;

	logic [9:0] ctrl;
	logic regDst;
	logic regimmBranch;

	assign regimmBranch = (instr.i.rt == rtBltz) || (instr.i.rt == rtBgez);

	// --------------------------------------------------
	// Control class
	// --------------------------------------------------
	always_comb begin
		case (instr.r.opcode)
			opSpecial: begin
				case (instr.r.funct)
					fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav,
					fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
					fnXor, fnNor, fnSlt, fnSltu: ctrl = ctrlRType;
					fnJr: ctrl = ctrlJump;
					fnJalr: ctrl = ctrlJalr;
					fnSyscall: ctrl = ctrlSyscall;
					default: ctrl = ctrlNone;
				endcase
			end
			opRegimm: ctrl = regimmBranch ? ctrlBranch : ctrlNone;
			opBeq, opBne, opBlez, opBgtz: ctrl = ctrlBranch;
			opJ: ctrl = ctrlJump;
			opJal: ctrl = ctrlJal;
			opAddi, opAddiu, opSlti, opSltiu,
			opAndi, opOri, opXori, opLui: ctrl = ctrlImm;
			opLb, opLbu, opLh, opLhu, opLw: ctrl = ctrlLoad;
			opSb, opSh, opSw: ctrl = ctrlStore;
			default: ctrl = ctrlNone;
		endcase
	end

	assign {link, regDst, jump, branch, memRead, memToReg, memWrite, aluSrc, regWrite,
		syscall} = ctrl;

	// --------------------------------------------------
	// ALU operation
	// --------------------------------------------------
	always_comb begin
		case (instr.r.opcode)
			opSpecial: begin
				case (instr.r.funct)
					fnSll: aluControl = aluSll;
					fnSrl: aluControl = aluSrl;
					fnSra: aluControl = aluSra;
					fnSllv: aluControl = aluSllv;
					fnSrlv: aluControl = aluSrlv;
					fnSrav: aluControl = aluSrav;
					fnJr: aluControl = aluJr;
					// Link and syscall add their two operands
					fnJalr, fnSyscall: aluControl = aluAddi;
					fnAdd: aluControl = aluAdd;
					fnAddu: aluControl = aluAddu;
					fnSub: aluControl = aluSub;
					fnSubu: aluControl = aluSubu;
					fnAnd: aluControl = aluAnd;
					fnOr: aluControl = aluOr;
					fnXor: aluControl = aluXor;
					fnNor: aluControl = aluNor;
					fnSlt: aluControl = aluSlt;
					fnSltu: aluControl = aluSltu;
					default: aluControl = '0;
				endcase
			end
			opRegimm: begin
				case (instr.i.rt)
					rtBltz: aluControl = aluBltz;
					rtBgez: aluControl = aluBgez;
					default: aluControl = '0;
				endcase
			end
			opJ: aluControl = aluPassB;
			opJal, opAddi: aluControl = aluAddi;
			opBeq: aluControl = aluBeq;
			opBne: aluControl = aluBne;
			opBlez: aluControl = aluBlez;
			opBgtz: aluControl = aluBgtz;
			opAddiu: aluControl = aluAddiu;
			opSlti, opSltiu: aluControl = aluSlt;
			opAndi: aluControl = aluAnd;
			opOri: aluControl = aluOr;
			opXori: aluControl = aluXori;
			opLui: aluControl = aluLui;
			opLb: aluControl = aluLb;
			opLbu: aluControl = aluLbu;
			opLh: aluControl = aluLh;
			opLhu: aluControl = aluLhu;
			opLw: aluControl = aluLw;
			opSb: aluControl = aluSb;
			opSh: aluControl = aluSh;
			opSw: aluControl = aluSw;
			default: aluControl = '0;
		endcase
	end

	// Destination register
	always_comb begin
		if (regDst)
			writeReg = instr.r.rd;
		else if (link)
			writeReg = linkRegister;
		else if (syscall)
			writeReg = '0;
		else
			writeReg = instr.i.rt;
	end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
// Register file, 32 words
// Three asynchronous read ports and one write port from writeback
`timescale 1ns/1ps
`default_nettype none

module regFile import decodePkg::*; (
	input logic CLK,
	input regIndex readRegA,
	input regIndex readRegB,
	input regIndex readRegC,
	input logic wbEnable,
	input regIndex wbReg,
	input logic [wordWidth-1:0] wbData,
	output logic [wordWidth-1:0] readDataA,
	output logic [wordWidth-1:0] readDataB,
	output logic [wordWidth-1:0] readDataC
);

	logic [wordWidth-1:0] regs [2**$bits(regIndex)];

	// Register 0 is never written
	always_ff @(posedge CLK) begin
		if (wbEnable && (wbReg != '0))
			regs[wbReg] <= wbData;
	end

	// Entry 0 holds no value, so it is forced to zero on read
	assign readDataA = (readRegA == '0) ? '0 : regs[readRegA];
	assign readDataB = (readRegB == '0) ? '0 : regs[readRegB];
	assign readDataC = (readRegC == '0) ? '0 : regs[readRegC];

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tb
hw/decodePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/branchResolver.sv
hw/idExRegister.sv
hw/decodeStage.sv
tb/clockGen.sv
tb/decodeStageTb.sv

// ==== tb/clockGen.sv ====
// Testbench clock and reset
// 20 ns clock, reset held low for the first five cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic CLK,
	output logic RESET
);

	localparam int period = 20;
	localparam int resetCycles = 5;

	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK;
	end

	// Release lands on a falling edge
	initial begin
		RESET = 1'b0;
		#(period * resetCycles) RESET = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/decodeModel.svh ====
// Reference model of the decode stage
// Expected controls, next fetch address and a shadow copy of the register file
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
	regIndex writeReg;
	aluOp aluControl;
	logic link;
	logic syscall;
	logic jump;
	logic branch;
	logic memRead;
	logic memToReg;
	logic memWrite;
	logic aluSrc;
	logic regWrite;
} decodeResult;

typedef struct packed {
	logic [wordWidth-1:0] operandA;
	logic [wordWidth-1:0] operandB;
	logic [wordWidth-1:0] readDataBOut;
	logic [wordWidth-1:0] destValueOut;
	logic [wordWidth-1:0] instrOut;
	regIndex writeRegOut;
	regIndex readRegAOut;
	regIndex readRegBOut;
	regIndex shamtOut;
	aluOp aluControlOut;
	logic memReadOut;
	logic memToRegOut;
	logic memWriteOut;
	logic aluSrcOut;
	logic doWriteback;
	logic branchTakenOut;
} idExState;

logic [wordWidth-1:0] shadow [32];

function automatic logic [wordWidth-1:0] readShadow(regIndex idx);
	return (idx == 0) ? '0 : shadow[idx];
endfunction

function automatic void writeShadow(regIndex idx, logic [wordWidth-1:0] data);
	if (idx != 0)
		shadow[idx] = data;
endfunction

// Valid flag on top of the ALU code
function automatic logic [6:0] rTypeAlu(logic [5:0] funct);
	case (funct)
		fnSll: return {1'b1, aluSll};
		fnSrl: return {1'b1, aluSrl};
		fnSra: return {1'b1, aluSra};
		fnSllv: return {1'b1, aluSllv};
		fnSrlv: return {1'b1, aluSrlv};
		fnSrav: return {1'b1, aluSrav};
		fnAdd: return {1'b1, aluAdd};
		fnAddu: return {1'b1, aluAddu};
		fnSub: return {1'b1, aluSub};
		fnSubu: return {1'b1, aluSubu};
		fnAnd: return {1'b1, aluAnd};
		fnOr: return {1'b1, aluOr};
		fnXor: return {1'b1, aluXor};
		fnNor: return {1'b1, aluNor};
		fnSlt: return {1'b1, aluSlt};
		fnSltu: return {1'b1, aluSltu};
		default: return '0;
	endcase
endfunction

function automatic aluOp opcodeAlu(logic [5:0] op);
	case (op)
		opJ: return aluPassB;
		opJal, opAddi: return aluAddi;
		opBeq: return aluBeq;
		opBne: return aluBne;
		opBlez: return aluBlez;
		opBgtz: return aluBgtz;
		opAddiu: return aluAddiu;
		opSlti, opSltiu: return aluSlt;
		opAndi: return aluAnd;
		opOri: return aluOr;
		opXori: return aluXori;
		opLui: return aluLui;
		opLb: return aluLb;
		opLbu: return aluLbu;
		opLh: return aluLh;
		opLhu: return aluLhu;
		opLw: return aluLw;
		opSb: return aluSb;
		opSh: return aluSh;
		opSw: return aluSw;
		default: return '0;
	endcase
endfunction

function automatic decodeResult expectedDecode(instrWord w);
	decodeResult d;
	logic [6:0] rAlu;
	d = '0;
	d.writeReg = w.i.rt;
	d.aluControl = opcodeAlu(w.i.opcode);
	rAlu = rTypeAlu(w.r.funct);
	case (w.i.opcode)
		opSpecial: begin
			if (rAlu[6]) begin
				d.aluControl = rAlu[5:0];
				d.regWrite = 1'b1;
				d.writeReg = w.r.rd;
			end else if (w.r.funct == fnJr) begin
				d.jump = 1'b1;
				d.branch = 1'b1;
				d.aluControl = aluJr;
			end else if (w.r.funct == fnJalr) begin
				d.link = 1'b1;
				d.jump = 1'b1;
				d.branch = 1'b1;
				d.regWrite = 1'b1;
				d.aluControl = aluAddi;
				d.writeReg = linkRegister;
			end else if (w.r.funct == fnSyscall) begin
				d.syscall = 1'b1;
				d.aluSrc = 1'b1;
				d.regWrite = 1'b1;
				d.aluControl = aluAddi;
				d.writeReg = '0;
			end
		end
		opRegimm: begin
			if (w.i.rt == rtBltz || w.i.rt == rtBgez) begin
				d.branch = 1'b1;
				d.aluControl = (w.i.rt == rtBltz) ? aluBltz : aluBgez;
			end
		end
		opBeq, opBne, opBlez, opBgtz: d.branch = 1'b1;
		opJ: begin
			d.jump = 1'b1;
			d.branch = 1'b1;
		end
		opJal: begin
			d.link = 1'b1;
			d.jump = 1'b1;
			d.aluSrc = 1'b1;
			d.regWrite = 1'b1;
			d.writeReg = linkRegister;
		end
		opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
			d.aluSrc = 1'b1;
			d.regWrite = 1'b1;
		end
		opLb, opLbu, opLh, opLhu, opLw: begin
			d.memRead = 1'b1;
			d.memToReg = 1'b1;
			d.aluSrc = 1'b1;
			d.regWrite = 1'b1;
		end
		opSb, opSh, opSw: begin
			d.memWrite = 1'b1;
			d.aluSrc = 1'b1;
		end
		default: d = d;
	endcase
	return d;
endfunction

// Taken flag on top of the next fetch address
function automatic logic [wordWidth:0] expectedNextPc(instrWord w, logic [wordWidth-1:0] p);
	decodeResult d;
	logic signed [wordWidth-1:0] a;
	logic signed [wordWidth-1:0] b;
	logic [wordWidth-1:0] offset;
	logic cond;
	d = expectedDecode(w);
	a = readShadow(w.i.rs);
	b = readShadow(w.i.rt);
	offset = wordWidth'($signed(w.i.imm)) << 2;
	case (w.i.opcode)
		opBeq: cond = (a == b);
		opBne: cond = (a != b);
		opBlez: cond = (a <= 0);
		opBgtz: cond = (a > 0);
		opRegimm: cond = (w.i.rt == rtBgez) ? (a >= 0) : (a < 0);
		default: cond = 1'b0;
	endcase
	if (d.jump && w.i.opcode == opSpecial)
		return {1'b1, a};
	if (d.jump)
		return {1'b1, p[wordWidth-1:wordWidth-4], w.j.target, 2'b00};
	if (d.branch && cond)
		return {1'b1, p + offset};
	return {1'b0, p};
endfunction

function automatic idExState expectedIdEx(instrWord w, logic [wordWidth-1:0] p,
		logic [wordWidth-1:0] r2);
	decodeResult d;
	idExState s;
	logic [wordWidth:0] branchResult;
	d = expectedDecode(w);
	branchResult = expectedNextPc(w, p);
	s = '0;
	s.operandA = d.link ? p : (d.syscall ? r2 : readShadow(w.r.rs));
	s.operandB = d.link ? 32'd4 : (d.syscall ? 32'd0 : readShadow(w.r.rt));
	s.readDataBOut = readShadow(w.r.rt);
	s.destValueOut = readShadow(d.writeReg);
	s.instrOut = w;
	s.writeRegOut = d.writeReg;
	s.readRegAOut = (d.link || d.syscall) ? 5'd0 : w.r.rs;
	s.readRegBOut = (d.aluSrc || d.link || d.syscall) ? 5'd0 : w.r.rt;
	s.shamtOut = w.r.shamt;
	s.aluControlOut = d.aluControl;
	s.memReadOut = d.memRead;
	s.memToRegOut = d.memToReg;
	s.memWriteOut = d.memWrite;
	s.aluSrcOut = d.aluSrc;
	s.doWriteback = d.regWrite || d.memToReg;
	s.branchTakenOut = branchResult[wordWidth];
	return s;
endfunction

`endif

// ==== tb/decodeStageTb.sv ====
// Testbench for the MIPS decode stage
// Random stimulus checked against a reference model every cycle
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb import decodePkg::*; ();

	localparam int clockPeriod = 20;
	localparam int rTypeCount = 40;
	localparam int immCount = 40;
	localparam int branchRounds = 6;
	localparam int syscallCount = 6;
	// Cycles per test: reset, registers, immediates, branches, syscall, hold
	localparam int watchdogCycles = 10 + (31 + 4 + rTypeCount) + (immCount + 2)
		+ (branchRounds * 8 + 10) + (syscallCount + 2) + 10 + 50;

	localparam logic [95:0] rFuncts = {fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav,
		fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
	localparam logic [95:0] immOps = {opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri,
		opXori, opLui, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
	localparam logic [35:0] branchOps = {opBeq, opBne, opBlez, opBgtz, opRegimm, opRegimm};

	logic CLK;
	logic RESET;
	instrWord instr;
	logic [wordWidth-1:0] pca, r2Input, wbData;
	logic wbEnable, freeze, insertBubble;
	regIndex wbReg;
	logic branchTaken;
	logic [wordWidth-1:0] nextPc, operandA, operandB, readDataBOut, destValueOut, instrOut;
	regIndex writeRegOut, readRegAOut, readRegBOut, shamtOut;
	aluOp aluControlOut;
	logic memReadOut, memToRegOut, memWriteOut, aluSrcOut, doWriteback, branchTakenOut;

	integer seed = 32'h73bf817b;
	int checkCount = 0;
	int errorCount = 0;
	int errorsBefore = 0;
	int testCount = 0;

	`include "decodeModel.svh"

	clockGen clockGen_i (.CLK(CLK), .RESET(RESET));

	decodeStage decodeStage_i (.CLK(CLK), .RESET(RESET), .instr(instr), .pca(pca),
		.r2Input(r2Input), .wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
		.freeze(freeze), .insertBubble(insertBubble), .branchTaken(branchTaken),
		.nextPc(nextPc), .operandA(operandA), .operandB(operandB),
		.readDataBOut(readDataBOut), .destValueOut(destValueOut), .instrOut(instrOut),
		.writeRegOut(writeRegOut), .readRegAOut(readRegAOut), .readRegBOut(readRegBOut),
		.shamtOut(shamtOut), .aluControlOut(aluControlOut), .memReadOut(memReadOut),
		.memToRegOut(memToRegOut), .memWriteOut(memWriteOut), .aluSrcOut(aluSrcOut),
		.doWriteback(doWriteback), .branchTakenOut(branchTakenOut));

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %0d ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic compareIdEx(input idExState s);
		checkValue("operandA", s.operandA, operandA);
		checkValue("operandB", s.operandB, operandB);
		checkValue("readDataBOut", s.readDataBOut, readDataBOut);
		checkValue("destValueOut", s.destValueOut, destValueOut);
		checkValue("instrOut", s.instrOut, instrOut);
		checkValue("writeRegOut", s.writeRegOut, writeRegOut);
		checkValue("readRegAOut", s.readRegAOut, readRegAOut);
		checkValue("readRegBOut", s.readRegBOut, readRegBOut);
		checkValue("shamtOut", s.shamtOut, shamtOut);
		checkValue("aluControlOut", s.aluControlOut, aluControlOut);
		checkValue("memReadOut", s.memReadOut, memReadOut);
		checkValue("memToRegOut", s.memToRegOut, memToRegOut);
		checkValue("memWriteOut", s.memWriteOut, memWriteOut);
		checkValue("aluSrcOut", s.aluSrcOut, aluSrcOut);
		checkValue("doWriteback", s.doWriteback, doWriteback);
		checkValue("branchTakenOut", s.branchTakenOut, branchTakenOut);
	endtask

	// --------------------------------------------------
	// Compare process
	// --------------------------------------------------
	initial begin : compareProcess
		idExState expState;
		idExState predicted;
		logic [wordWidth:0] branchResult;
		logic sampledFreeze, sampledBubble, sampledWrite;
		regIndex sampledReg;
		logic [wordWidth-1:0] sampledData;
		expState = '0;
		@(posedge CLK);
		forever begin
			@(negedge CLK);
			compareIdEx(expState);
			branchResult = expectedNextPc(instr, pca);
			checkValue("branchTaken", branchResult[wordWidth], branchTaken);
			checkValue("nextPc", branchResult[wordWidth-1:0], nextPc);
			predicted = expectedIdEx(instr, pca, r2Input);
			sampledFreeze = freeze;
			sampledBubble = insertBubble;
			sampledWrite = wbEnable;
			sampledReg = wbReg;
			sampledData = wbData;
			@(posedge CLK);
			if (!RESET || sampledBubble)
				expState = '0;
			else if (!sampledFreeze)
				expState = predicted;
			if (sampledWrite)
				writeShadow(sampledReg, sampledData);
		end
	end

	initial begin : watchdog
		#(watchdogCycles * clockPeriod);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Verification failed");
		$finish;
	end

	function automatic instrWord randomRType();
		instrWord w;
		int k;
		k = {$random(seed)} % 16;
		w = $random(seed);
		w.r.opcode = opSpecial;
		w.r.funct = rFuncts[k*6 +: 6];
		return w;
	endfunction

	function automatic instrWord randomImm();
		instrWord w;
		int k;
		k = {$random(seed)} % 16;
		w = $random(seed);
		w.i.opcode = immOps[k*6 +: 6];
		return w;
	endfunction

	task automatic drive(input instrWord w, input logic [31:0] p, input logic [31:0] r2,
			input logic f, input logic b);
		@(posedge CLK);
		instr <= w;
		pca <= p;
		r2Input <= r2;
		freeze <= f;
		insertBubble <= b;
		wbEnable <= 1'b0;
	endtask

	task automatic writeRegister(input regIndex idx, input logic [31:0] data);
		@(posedge CLK);
		instr <= '0;
		freeze <= 1'b0;
		insertBubble <= 1'b0;
		wbEnable <= 1'b1;
		wbReg <= idx;
		wbData <= data;
	endtask

	// Last result is compared at the falling edge before the report
	task automatic finishTest(input string name);
		drive('0, '0, '0, 1'b0, 1'b0);
		@(posedge CLK);
		testCount++;
		$display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		errorsBefore = errorCount;
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	initial begin : stimulus
		instrWord w;
		logic [31:0] valueA, valueB;
		instr = '0;
		pca = '0;
		r2Input = '0;
		wbEnable = 1'b0;
		wbReg = '0;
		wbData = '0;
		freeze = 1'b1;
		insertBubble = 1'b0;

		// Outputs stay clear through reset and while held afterwards
		wait (RESET === 1'b1);
		repeat (3) drive('0, '0, '0, 1'b1, 1'b0);
		finishTest("reset");

		for (int i = 1; i < 32; i++)
			writeRegister(regIndex'(i), $random(seed));
		writeRegister('0, $random(seed));
		w = randomRType();
		w.r.rs = '0;
		w.r.rt = '0;
		drive(w, $random(seed), '0, 1'b0, 1'b0);
		for (int i = 0; i < rTypeCount; i++)
			drive(randomRType(), $random(seed), '0, 1'b0, 1'b0);
		finishTest("register file and R-type");

		for (int i = 0; i < immCount; i++)
			drive(randomImm(), $random(seed), '0, 1'b0, 1'b0);
		finishTest("immediate, load and store");

		for (int round = 0; round < branchRounds; round++) begin
			case (round % 3)
				0: valueA = '0;
				1: valueA = ($random(seed) & 32'h7fff_ffff) | 32'd1;
				default: valueA = $random(seed) | 32'h8000_0000;
			endcase
			valueB = (round % 2 == 0) ? valueA : $random(seed);
			writeRegister(5'd5, valueA);
			writeRegister(5'd6, valueB);
			for (int k = 0; k < 6; k++) begin
				w = $random(seed);
				w.i.opcode = branchOps[(5-k)*6 +: 6];
				w.i.rs = 5'd5;
				w.i.rt = (k == 4) ? rtBltz : ((k == 5) ? rtBgez : 5'd6);
				drive(w, $random(seed), '0, 1'b0, 1'b0);
			end
		end
		for (int k = 0; k < 8; k++) begin
			w = $random(seed);
			case (k % 4)
				0: w.j.opcode = opJ;
				1: w.j.opcode = opJal;
				2: w.r.funct = fnJr;
				default: w.r.funct = fnJalr;
			endcase
			if (k % 4 >= 2)
				w.r.opcode = opSpecial;
			drive(w, $random(seed), '0, 1'b0, 1'b0);
		end
		finishTest("branches and jumps");

		for (int i = 0; i < syscallCount; i++) begin
			w = $random(seed);
			w.r.opcode = opSpecial;
			w.r.funct = fnSyscall;
			drive(w, $random(seed), $random(seed), 1'b0, 1'b0);
		end
		finishTest("syscall");

		drive(randomRType(), $random(seed), '0, 1'b0, 1'b0);
		repeat (3) drive(randomRType(), $random(seed), '0, 1'b1, 1'b0);
		drive(randomImm(), $random(seed), '0, 1'b0, 1'b1);
		drive(randomRType(), $random(seed), '0, 1'b0, 1'b0);
		// Bubble wins over freeze
		drive(randomImm(), $random(seed), '0, 1'b1, 1'b1);
		drive(randomRType(), $random(seed), '0, 1'b1, 1'b0);
		drive(randomRType(), $random(seed), '0, 1'b0, 1'b0);
		finishTest("freeze and bubble");

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
